/* mem_pipe.f */
logic/mem_pkg.sv
logic/load_if.sv
logic/muldiv_if.sv
logic/load_unit.sv
logic/muldiv_unit.sv
logic/mem_stage.sv
logic/mem_pipe.sv
tests/mem_pipe_assertions.sv
tests/tb_mem_pipe.sv

/* tests/tb_mem_pipe.sv */
`timescale 1ns/1ns

module tb_mem_pipe;

    localparam int CLK_PERIOD = 4;
    // instructions issued by all tests together
    localparam int NUM_INSTR = 61;
    localparam int WATCHDOG_CYCLES = NUM_INSTR * 12 + 200;

    typedef struct {
        mem_pkg::word_t      pc;
        mem_pkg::load_op_t   load_op;
        mem_pkg::addr_low_t  off;
        mem_pkg::muldiv_op_t md_op;
        logic                md_signed;
        mem_pkg::word_t      a;
        mem_pkg::word_t      b;
        mem_pkg::word_t      alu;
        mem_pkg::reg_idx_t   dest;
        logic                rf_we;
        logic                excp;
        mem_pkg::excp_code_t num;
        mem_pkg::word_t      exp_result;
        logic                chk_result;
        logic                timed;
        logic                to_wb;
    } instr_t;

    logic                clk;
    logic                reset;
    logic                es_to_ms_valid;
    mem_pkg::word_t      es_pc;
    mem_pkg::load_op_t   es_load_op;
    mem_pkg::addr_low_t  es_addr_low;
    mem_pkg::muldiv_op_t es_md_op;
    logic                es_md_signed;
    mem_pkg::word_t      es_src_a;
    mem_pkg::word_t      es_src_b;
    mem_pkg::word_t      es_alu_result;
    mem_pkg::reg_idx_t   es_dest;
    logic                es_rf_we;
    logic                es_excp;
    mem_pkg::excp_code_t es_excp_num;
    logic                es_ertn;
    logic                ws_allowin;
    logic                excp_flush;
    logic                ertn_flush;
    mem_pkg::word_t      data_sram_rdata;
    logic                data_sram_data_ok;
    logic                ms_allowin;
    logic                ms_to_ws_valid;
    mem_pkg::word_t      ws_pc;
    mem_pkg::reg_idx_t   ws_dest;
    logic                ws_rf_we;
    mem_pkg::word_t      ws_result;
    logic                ws_excp;
    mem_pkg::excp_code_t ws_excp_num;
    logic                ms_ex;
    logic                fwd_valid;
    logic                fwd_we;
    mem_pkg::reg_idx_t   fwd_dest;
    mem_pkg::word_t      fwd_result;
    logic                fwd_pending;

    int             errors = 0;
    int             total_fails;
    int             load_delay = 1;
    mem_pkg::word_t load_word = '0;
    int             resp_wait_q[$];
    mem_pkg::word_t resp_word_q[$];
    instr_t         wb_q[$];
    time            due_q[$];
    instr_t         mon_item;
    time            mon_due;

    mem_pipe i_mem_pipe (.*);

    bind mem_pipe mem_pipe_assertions i_mem_pipe_assertions (.*);

    always #2 clk = ~clk;

    task automatic check_word(input string name, input mem_pkg::word_t got,
                              input mem_pkg::word_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_dest(input string name, input mem_pkg::reg_idx_t got,
                              input mem_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_excp(input string name, input mem_pkg::excp_code_t got,
                              input mem_pkg::excp_code_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // byte lanes are little endian, odd halfword offsets read as zero
    function automatic mem_pkg::word_t load_value(input mem_pkg::load_op_t op,
                                                  input mem_pkg::addr_low_t off,
                                                  input mem_pkg::word_t w);
        mem_pkg::word_t sh;
        sh = w >> (8 * off);
        case (op)
            mem_pkg::LD_B:  return {{24{sh[7]}}, sh[7:0]};
            mem_pkg::LD_BU: return {24'h000000, sh[7:0]};
            mem_pkg::LD_H:  return off[0] ? 32'h0 : {{16{sh[15]}}, sh[15:0]};
            mem_pkg::LD_HU: return off[0] ? 32'h0 : {16'h0000, sh[15:0]};
            default:        return w;
        endcase
    endfunction

    function automatic mem_pkg::word_t muldiv_value(input mem_pkg::muldiv_op_t op,
                                                    input logic sgn,
                                                    input mem_pkg::word_t a,
                                                    input mem_pkg::word_t b);
        longint         sa;
        longint         sb;
        mem_pkg::dword_t p;
        mem_pkg::word_t  q;
        mem_pkg::word_t  r;
        sa = sgn ? longint'($signed(a)) : longint'({32'h0, a});
        sb = sgn ? longint'($signed(b)) : longint'({32'h0, b});
        p = sa * sb;
        if (b == 32'h0) begin
            q = 32'hffff_ffff;
            r = a;
        end else begin
            // min / -1 wraps back to min in the low word
            q = 32'(sa / sb);
            r = 32'(sa % sb);
        end
        case (op)
            mem_pkg::MD_MUL_LO: return p[31:0];
            mem_pkg::MD_MUL_HI: return p[63:32];
            mem_pkg::MD_DIV:    return q;
            default:            return r;
        endcase
    endfunction

    function automatic instr_t blank(input mem_pkg::word_t pc, input mem_pkg::reg_idx_t dest,
                                     input mem_pkg::word_t alu);
        instr_t it;
        it.pc = pc;
        it.load_op = mem_pkg::LD_NONE;
        it.off = 2'b00;
        it.md_op = mem_pkg::MD_NONE;
        it.md_signed = 1'b0;
        it.a = 32'h0;
        it.b = 32'h0;
        it.alu = alu;
        it.dest = dest;
        it.rf_we = 1'b1;
        it.excp = 1'b0;
        it.num = 16'h0;
        it.exp_result = alu;
        it.chk_result = 1'b1;
        it.timed = 1'b1;
        it.to_wb = 1'b1;
        return it;
    endfunction

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic drive(input instr_t it);
        es_pc = it.pc;
        es_load_op = it.load_op;
        es_addr_low = it.off;
        es_md_op = it.md_op;
        es_md_signed = it.md_signed;
        es_src_a = it.a;
        es_src_b = it.b;
        es_alu_result = it.alu;
        es_dest = it.dest;
        es_rf_we = it.rf_we;
        es_excp = it.excp;
        es_excp_num = it.num;
    endtask

    // returns 1 ns after the edge that took the instruction
    task automatic send(input instr_t it);
        drive(it);
        es_to_ms_valid = 1'b1;
        @(negedge clk);
        while (!ms_allowin) begin
            @(negedge clk);
        end
        if (it.to_wb) begin
            wb_q.push_back(it);
            due_q.push_back(it.timed ? $time + CLK_PERIOD : 0);
        end
        next_edge();
        es_to_ms_valid = 1'b0;
    endtask

    task automatic drain();
        while (wb_q.size() != 0) begin
            @(negedge clk);
        end
        next_edge();
    endtask

    // data memory model, responses return in request order
    always @(negedge clk) begin
        if (!reset && es_to_ms_valid && ms_allowin && !es_excp && !es_ertn
                && es_load_op != mem_pkg::LD_NONE) begin
            resp_wait_q.push_back(load_delay);
            resp_word_q.push_back(load_word);
        end
    end

    always @(posedge clk) begin
        #1;
        data_sram_data_ok = 1'b0;
        if (resp_wait_q.size() != 0) begin
            resp_wait_q[0] = resp_wait_q[0] - 1;
            if (resp_wait_q[0] == 0) begin
                data_sram_data_ok = 1'b1;
                data_sram_rdata = resp_word_q.pop_front();
                resp_wait_q.delete(0);
            end
        end
    end

    // writeback scoreboard
    always @(negedge clk) begin
        if (!reset && ms_to_ws_valid && ws_allowin) begin
            if (wb_q.size() == 0) begin
                $display("error at %0t: unexpected instruction at pc %h reached writeback",
                         $time, ws_pc);
                errors++;
            end else begin
                mon_item = wb_q.pop_front();
                mon_due = due_q.pop_front();
                check_word("ws_pc", ws_pc, mon_item.pc);
                check_dest("ws_dest", ws_dest, mon_item.dest);
                check_bit("ws_rf_we", ws_rf_we, mon_item.rf_we);
                check_bit("ws_excp", ws_excp, mon_item.excp);
                check_bit("ms_ex", ms_ex, mon_item.excp);
                check_bit("fwd_valid", fwd_valid, 1'b1);
                check_bit("fwd_we", fwd_we, mon_item.rf_we);
                check_dest("fwd_dest", fwd_dest, mon_item.dest);
                if (mon_item.excp) begin
                    check_excp("ws_excp_num", ws_excp_num, mon_item.num);
                end
                if (mon_item.chk_result) begin
                    check_word("ws_result", ws_result, mon_item.exp_result);
                    check_word("fwd_result", fwd_result, mon_item.exp_result);
                end
                if (mon_due != 0 && $time != mon_due) begin
                    $display("error at %0t: pc %h reached writeback late, due at %0t",
                             $time, ws_pc, mon_due);
                    errors++;
                end
            end
        end
    end

    task automatic alu_passthrough_test();
        time    t0;
        instr_t it;
        for (int i = 0; i < 8; i++) begin
            t0 = $time;
            it = blank(32'h1000 + 4 * i, 5'(i + 1), $urandom);
            it.rf_we = i[0];
            send(it);
            if ($time - t0 != CLK_PERIOD) begin
                $display("error at %0t: instruction %0d was not taken in its first cycle",
                         $time, i);
                errors++;
            end
        end
        drain();
    endtask

    task automatic run_load(input mem_pkg::load_op_t op, input mem_pkg::addr_low_t off,
                            input mem_pkg::word_t word, input int delay);
        instr_t it;
        it = blank(32'h2000 + {28'h0, op, 1'b0}, 5'(8 + off), $urandom);
        it.load_op = op;
        it.off = off;
        it.exp_result = load_value(op, off, word);
        it.timed = 1'b0;
        load_word = word;
        load_delay = delay;
        send(it);
        @(negedge clk);
        while (!ms_to_ws_valid) begin
            check_bit("fwd_pending", fwd_pending, 1'b1);
            @(negedge clk);
        end
        check_bit("fwd_pending", fwd_pending, 1'b0);
        next_edge();
    endtask

    task automatic load_extend_test();
        for (int op = 1; op <= 5; op++) begin
            for (int off = 0; off < 4; off++) begin
                if (op != 1 || off == 0) begin
                    run_load(mem_pkg::load_op_t'(op), mem_pkg::addr_low_t'(off),
                             $urandom, 1 + ($urandom % 4));
                end
            end
        end
        drain();
    endtask

    task automatic send_md(input mem_pkg::muldiv_op_t op, input logic sgn,
                           input mem_pkg::word_t a, input mem_pkg::word_t b);
        instr_t it;
        it = blank(32'h3000 + {29'h0, op} * 4, 5'd20, $urandom);
        it.md_op = op;
        it.md_signed = sgn;
        it.a = a;
        it.b = b;
        it.exp_result = muldiv_value(op, sgn, a, b);
        send(it);
    endtask

    task automatic muldiv_test();
        for (int op = 1; op <= 4; op++) begin
            for (int sgn = 0; sgn < 2; sgn++) begin
                repeat (3) begin
                    send_md(mem_pkg::muldiv_op_t'(op), sgn[0], $urandom, $urandom);
                end
            end
        end
        send_md(mem_pkg::MD_DIV, 1'b1, $urandom, 32'h0);
        send_md(mem_pkg::MD_MOD, 1'b1, $urandom, 32'h0);
        send_md(mem_pkg::MD_DIV, 1'b0, $urandom, 32'h0);
        send_md(mem_pkg::MD_MOD, 1'b0, $urandom, 32'h0);
        send_md(mem_pkg::MD_DIV, 1'b1, 32'h8000_0000, 32'hffff_ffff);
        send_md(mem_pkg::MD_MOD, 1'b1, 32'h8000_0000, 32'hffff_ffff);
        drain();
    endtask

    task automatic backpressure_test();
        instr_t first;
        instr_t second;
        first = blank(32'h5000, 5'd3, 32'h1111_2222);
        first.timed = 1'b0;
        second = blank(32'h5004, 5'd4, 32'h3333_4444);
        ws_allowin = 1'b0;
        send(first);
        // second waits at the input the whole time
        drive(second);
        es_to_ms_valid = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_bit("ms_to_ws_valid", ms_to_ws_valid, 1'b1);
            check_bit("ms_allowin", ms_allowin, 1'b0);
            check_word("ws_pc", ws_pc, first.pc);
            check_word("ws_result", ws_result, first.alu);
        end
        next_edge();
        ws_allowin = 1'b1;
        send(second);
        drain();
    endtask

    task automatic flush_test();
        instr_t it;
        it = blank(32'h6000, 5'd7, 32'h0);
        it.load_op = mem_pkg::LD_W;
        it.to_wb = 1'b0;
        load_word = 32'hbad0_0bad;
        load_delay = 4;
        send(it);
        excp_flush = 1'b1;
        @(negedge clk);
        check_bit("ms_to_ws_valid", ms_to_ws_valid, 1'b0);
        check_bit("ms_allowin", ms_allowin, 1'b1);
        next_edge();
        excp_flush = 1'b0;
        check_bit("fwd_valid", fwd_valid, 1'b0);
        // next load enters while the killed response is still on its way
        run_load(mem_pkg::LD_W, 2'b00, 32'h600d_f00d, 1);
        drain();
    endtask

    task automatic exception_test();
        instr_t it;
        it = blank(32'h7000, 5'd9, 32'h0);
        it.load_op = mem_pkg::LD_W;
        it.excp = 1'b1;
        it.num = 16'h0008;
        it.chk_result = 1'b0;
        send(it);
        it = blank(32'h7004, 5'd10, 32'h0);
        it.rf_we = 1'b0;
        it.excp = 1'b1;
        it.num = 16'h000b;
        it.chk_result = 1'b0;
        send(it);
        drain();
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h733f));
        clk = 1'b0;
        reset = 1'b1;
        es_to_ms_valid = 1'b0;
        drive(blank(32'h0, 5'd0, 32'h0));
        es_ertn = 1'b0;
        ws_allowin = 1'b1;
        excp_flush = 1'b0;
        ertn_flush = 1'b0;
        data_sram_rdata = 32'h0;
        data_sram_data_ok = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        alu_passthrough_test();
        load_extend_test();
        muldiv_test();
        backpressure_test();
        flush_test();
        exception_test();
        total_fails = errors + i_mem_pipe.i_mem_pipe_assertions.fail_count;
        $display("failed checks: %0d, failed assertions: %0d", errors,
                 i_mem_pipe.i_mem_pipe_assertions.fail_count);
        if (total_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* tests/mem_pipe_assertions.sv */
`timescale 1ns/1ns

module mem_pipe_assertions (
    input logic                clk,
    input logic                reset,
    input logic                es_to_ms_valid,
    input logic                excp_flush,
    input logic                ertn_flush,
    input logic                ws_allowin,
    input logic                ms_allowin,
    input logic                ms_to_ws_valid,
    input mem_pkg::word_t      ws_pc,
    input mem_pkg::reg_idx_t   ws_dest,
    input logic                ws_rf_we,
    input mem_pkg::word_t      ws_result,
    input logic                ws_excp,
    input mem_pkg::excp_code_t ws_excp_num
);

    int   fail_count = 0;
    logic occupied;

    // stage occupancy rebuilt from the handshakes
    always_ff @(posedge clk) begin
        if (reset) begin
            occupied <= 1'b0;
        end else if (es_to_ms_valid && ms_allowin) begin
            occupied <= 1'b1;
        end else if ((ms_to_ws_valid && ws_allowin) || excp_flush || ertn_flush) begin
            occupied <= 1'b0;
        end
    end

    // a killed instruction is never offered
    no_valid_in_flush: assert property (@(posedge clk) disable iff (reset)
        (excp_flush || ertn_flush) |-> !ms_to_ws_valid)
    else begin
        $error("ms_to_ws_valid high during a flush");
        fail_count++;
    end

    hold_under_backpressure: assert property (@(posedge clk) disable iff (reset)
        (ms_to_ws_valid && !ws_allowin && !excp_flush && !ertn_flush)
        |=> ($stable(ws_pc) && $stable(ws_dest) && $stable(ws_rf_we)
             && $stable(ws_result) && $stable(ws_excp) && $stable(ws_excp_num)))
    else begin
        $error("writeback outputs changed while stalled");
        fail_count++;
    end

    allowin_when_empty: assert property (@(posedge clk) disable iff (reset)
        !occupied |-> ms_allowin)
    else begin
        $error("ms_allowin low with an empty stage");
        fail_count++;
    end

endmodule

/* logic/mem_pipe.sv */
`timescale 1ns/1ns

module mem_pipe (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 es_to_ms_valid,
    input  mem_pkg::word_t       es_pc,
    input  mem_pkg::load_op_t    es_load_op,
    input  mem_pkg::addr_low_t   es_addr_low,
    input  mem_pkg::muldiv_op_t  es_md_op,
    input  logic                 es_md_signed,
    input  mem_pkg::word_t       es_src_a,
    input  mem_pkg::word_t       es_src_b,
    input  mem_pkg::word_t       es_alu_result,
    input  mem_pkg::reg_idx_t    es_dest,
    input  logic                 es_rf_we,
    input  logic                 es_excp,
    input  mem_pkg::excp_code_t  es_excp_num,
    input  logic                 es_ertn,
    input  logic                 ws_allowin,
    input  logic                 excp_flush,
    input  logic                 ertn_flush,
    input  mem_pkg::word_t       data_sram_rdata,
    input  logic                 data_sram_data_ok,
    output logic                 ms_allowin,
    output logic                 ms_to_ws_valid,
    output mem_pkg::word_t       ws_pc,
    output mem_pkg::reg_idx_t    ws_dest,
    output logic                 ws_rf_we,
    output mem_pkg::word_t       ws_result,
    output logic                 ws_excp,
    output mem_pkg::excp_code_t  ws_excp_num,
    output logic                 ms_ex,
    output logic                 fwd_valid,
    output logic                 fwd_we,
    output mem_pkg::reg_idx_t    fwd_dest,
    output mem_pkg::word_t       fwd_result,
    output logic                 fwd_pending
);

    load_if   ld_bus ();
    muldiv_if md_bus ();

    mem_stage i_mem_stage (
        .ld (ld_bus.stage),
        .md (md_bus.stage),
        .*
    );

    load_unit i_load_unit (
        .clk               (clk),
        .reset             (reset),
        .data_sram_rdata   (data_sram_rdata),
        .data_sram_data_ok (data_sram_data_ok),
        .ld                (ld_bus.unit)
    );

    muldiv_unit i_muldiv_unit (
        .clk   (clk),
        .reset (reset),
        .md    (md_bus.unit)
    );

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 es_to_ms_valid,
    input  mem_pkg::word_t       es_pc,
    input  mem_pkg::load_op_t    es_load_op,
    input  mem_pkg::addr_low_t   es_addr_low,
    input  mem_pkg::muldiv_op_t  es_md_op,
    input  logic                 es_md_signed,
    input  mem_pkg::word_t       es_src_a,
    input  mem_pkg::word_t       es_src_b,
    input  mem_pkg::word_t       es_alu_result,
    input  mem_pkg::reg_idx_t    es_dest,
    input  logic                 es_rf_we,
    input  logic                 es_excp,
    input  mem_pkg::excp_code_t  es_excp_num,
    input  logic                 es_ertn,
    input  logic                 ws_allowin,
    input  logic                 excp_flush,
    input  logic                 ertn_flush,
    output logic                 ms_allowin,
    output logic                 ms_to_ws_valid,
    output mem_pkg::word_t       ws_pc,
    output mem_pkg::reg_idx_t    ws_dest,
    output logic                 ws_rf_we,
    output mem_pkg::word_t       ws_result,
    output logic                 ws_excp,
    output mem_pkg::excp_code_t  ws_excp_num,
    output logic                 ms_ex,
    output logic                 fwd_valid,
    output logic                 fwd_we,
    output mem_pkg::reg_idx_t    fwd_dest,
    output mem_pkg::word_t       fwd_result,
    output logic                 fwd_pending,
    load_if.stage                ld,
    muldiv_if.stage              md
);

    logic                ms_valid;
    logic                flush;
    logic                stall;
    logic                ready_go;
    logic                accept;
    logic                is_load;
    mem_pkg::load_op_t   ms_load_op;
    mem_pkg::word_t      final_result;

    mem_pkg::word_t      pc_r;
    mem_pkg::load_op_t   load_op_r;
    mem_pkg::addr_low_t  addr_low_r;
    mem_pkg::muldiv_op_t md_op_r;
    mem_pkg::word_t      alu_result_r;
    mem_pkg::reg_idx_t   dest_r;
    logic                rf_we_r;
    logic                excp_r;
    mem_pkg::excp_code_t excp_num_r;
    logic                ertn_r;

    assign flush          = excp_flush || ertn_flush;
    assign stall          = is_load && !ld.held && !ms_ex;
    assign ready_go       = !flush && !stall;
    assign ms_allowin     = !ms_valid || (ready_go && ws_allowin) || flush;
    assign ms_to_ws_valid = ms_valid && ready_go;
    assign accept         = es_to_ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_r         <= es_pc;
            load_op_r    <= es_load_op;
            addr_low_r   <= es_addr_low;
            md_op_r      <= es_md_op;
            alu_result_r <= es_alu_result;
            dest_r       <= es_dest;
            rf_we_r      <= es_rf_we;
            excp_r       <= es_excp;
            excp_num_r   <= es_excp_num;
            ertn_r       <= es_ertn;
        end
    end

    assign ms_ex = ms_valid && (excp_r || ertn_r);

    // a trapped load never issued its request
    assign ms_load_op = (excp_r || ertn_r) ? mem_pkg::LD_NONE : load_op_r;
    assign is_load    = (ms_load_op != mem_pkg::LD_NONE);

    assign ld.accept   = accept;
    assign ld.load_op  = ms_load_op;
    assign ld.addr_low = addr_low_r;
    assign ld.leave    = ms_to_ws_valid && ws_allowin;
    assign ld.flush    = flush;

    assign md.accept    = accept;
    assign md.op        = es_md_op;
    assign md.is_signed = es_md_signed;
    assign md.src_a     = es_src_a;
    assign md.src_b     = es_src_b;

    assign final_result = is_load                        ? ld.data   :
                          (md_op_r != mem_pkg::MD_NONE)  ? md.result :
                                                           alu_result_r;

    assign ws_pc       = pc_r;
    assign ws_dest     = dest_r;
    assign ws_rf_we    = rf_we_r;
    assign ws_result   = final_result;
    assign ws_excp     = excp_r;
    assign ws_excp_num = excp_num_r;

    // decode stalls on fwd_pending
    assign fwd_valid   = ms_valid;
    assign fwd_we      = rf_we_r;
    assign fwd_dest    = dest_r;
    assign fwd_result  = final_result;
    assign fwd_pending = ms_valid && stall;

endmodule

/* logic/muldiv_unit.sv */
`timescale 1ns/1ns

module muldiv_unit (
    input  logic  clk,
    input  logic  reset,
    muldiv_if.unit md
);

    mem_pkg::muldiv_op_t op_r;
    logic                signed_r;
    mem_pkg::word_t      a_r;
    mem_pkg::word_t      b_r;
    logic signed [32:0]  ext_a;
    logic signed [32:0]  ext_b;
    logic signed [65:0]  prod_full;
    mem_pkg::dword_t     product;
    mem_pkg::word_t      mag_a;
    mem_pkg::word_t      mag_b;
    mem_pkg::word_t      quot;
    mem_pkg::word_t      rem;
    logic                q_neg;
    logic                r_neg;

    always_ff @(posedge clk) begin
        if (reset) begin
            op_r <= mem_pkg::MD_NONE;
        end else if (md.accept) begin
            op_r <= md.op;
        end
    end

    always_ff @(posedge clk) begin
        if (md.accept) begin
            signed_r <= md.is_signed;
            a_r      <= md.src_a;
            b_r      <= md.src_b;
        end
    end

    // one 33x33 signed multiplier covers both signednesses
    assign ext_a     = {signed_r & a_r[31], a_r};
    assign ext_b     = {signed_r & b_r[31], b_r};
    assign prod_full = ext_a * ext_b;
    assign product   = prod_full[63:0];

    assign mag_a = (signed_r && a_r[31]) ? -a_r : a_r;
    assign mag_b = (signed_r && b_r[31]) ? -b_r : b_r;
    assign q_neg = signed_r && (a_r[31] ^ b_r[31]);
    assign r_neg = signed_r && a_r[31];

    always_comb begin
        if (b_r == '0) begin
            quot = '1;
            rem  = a_r;
        end else begin
            quot = q_neg ? -(mag_a / mag_b) : (mag_a / mag_b);
            rem  = r_neg ? -(mag_a % mag_b) : (mag_a % mag_b);
        end
    end

    always_comb begin
        case (op_r)
            mem_pkg::MD_MUL_LO: md.result = product[31:0];
            mem_pkg::MD_MUL_HI: md.result = product[63:32];
            mem_pkg::MD_DIV:    md.result = quot;
            mem_pkg::MD_MOD:    md.result = rem;
            default:            md.result = '0;
        endcase
    end

endmodule

/* logic/load_unit.sv */
`timescale 1ns/1ns

module load_unit (
    input  logic           clk,
    input  logic           reset,
    input  mem_pkg::word_t data_sram_rdata,
    input  logic           data_sram_data_ok,
    load_if.unit           ld
);

    mem_pkg::load_state_t state;
    mem_pkg::load_state_t state_next;
    mem_pkg::word_t       rdata_buf;
    logic                 live;
    logic                 waiting;
    logic                 capture;
    logic [7:0]           byte_sel;
    logic [15:0]          half_sel;

    // stage holds an instruction that still expects its data_ok
    assign waiting = live && (ld.load_op != mem_pkg::LD_NONE);
    assign capture = (state == mem_pkg::LD_WAIT) && waiting && data_sram_data_ok && !ld.flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            live <= 1'b0;
        end else if (ld.accept) begin
            live <= 1'b1;
        end else if (ld.leave || ld.flush) begin
            live <= 1'b0;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            mem_pkg::LD_WAIT: begin
                if (ld.flush && waiting && !data_sram_data_ok) begin
                    state_next = mem_pkg::LD_DROP;
                end else if (capture) begin
                    state_next = mem_pkg::LD_HELD;
                end
            end
            mem_pkg::LD_HELD: begin
                if (ld.leave || ld.flush) begin
                    state_next = mem_pkg::LD_WAIT;
                end
            end
            mem_pkg::LD_DROP: begin
                // late response of a killed load
                if (data_sram_data_ok) begin
                    state_next = mem_pkg::LD_WAIT;
                end
            end
            default: state_next = mem_pkg::LD_WAIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mem_pkg::LD_WAIT;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_buf <= data_sram_rdata;
        end
    end

    assign ld.held = (state == mem_pkg::LD_HELD);

    always_comb begin
        case (ld.addr_low)
            2'b00:   byte_sel = rdata_buf[7:0];
            2'b01:   byte_sel = rdata_buf[15:8];
            2'b10:   byte_sel = rdata_buf[23:16];
            default: byte_sel = rdata_buf[31:24];
        endcase
    end

    // odd halfword offsets are trapped upstream
    assign half_sel = (ld.addr_low == 2'b00) ? rdata_buf[15:0]  :
                      (ld.addr_low == 2'b10) ? rdata_buf[31:16] : 16'h0000;

    always_comb begin
        case (ld.load_op)
            mem_pkg::LD_W:  ld.data = rdata_buf;
            mem_pkg::LD_B:  ld.data = {{24{byte_sel[7]}}, byte_sel};
            mem_pkg::LD_BU: ld.data = {24'h000000, byte_sel};
            mem_pkg::LD_H:  ld.data = {{16{half_sel[15]}}, half_sel};
            mem_pkg::LD_HU: ld.data = {16'h0000, half_sel};
            default:        ld.data = '0;
        endcase
    end

endmodule

/* logic/muldiv_if.sv */
`timescale 1ns/1ns

interface muldiv_if;
    logic                accept;
    mem_pkg::muldiv_op_t op;
    logic                is_signed;
    mem_pkg::word_t      src_a;
    mem_pkg::word_t      src_b;
    mem_pkg::word_t      result;

    // operands are sampled together with accept
    modport stage (
        output accept,
        output op,
        output is_signed,
        output src_a,
        output src_b,
        input  result
    );

    modport unit (
        input  accept,
        input  op,
        input  is_signed,
        input  src_a,
        input  src_b,
        output result
    );
endinterface

/* logic/load_if.sv */
`timescale 1ns/1ns

interface load_if;
    logic                accept;
    mem_pkg::load_op_t   load_op;
    mem_pkg::addr_low_t  addr_low;
    logic                leave;
    logic                flush;
    mem_pkg::word_t      data;
    logic                held;

    modport stage (
        output accept,
        output load_op,
        output addr_low,
        output leave,
        output flush,
        input  data,
        input  held
    );

    modport unit (
        input  accept,
        input  load_op,
        input  addr_low,
        input  leave,
        input  flush,
        output data,
        output held
    );
endinterface

/* logic/mem_pkg.sv */
package mem_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int EXCP_W    = 16;
    localparam int OP_W      = 3;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [2*WORD_W-1:0]  dword_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [EXCP_W-1:0]    excp_code_t;
    typedef logic [1:0]           addr_low_t;
    typedef logic [OP_W-1:0]      load_op_t;
    typedef logic [OP_W-1:0]      muldiv_op_t;

    // load kinds
    localparam load_op_t LD_NONE = 3'd0;
    localparam load_op_t LD_W    = 3'd1;
    localparam load_op_t LD_B    = 3'd2;
    localparam load_op_t LD_BU   = 3'd3;
    localparam load_op_t LD_H    = 3'd4;
    localparam load_op_t LD_HU   = 3'd5;

    // multiply / divide kinds
    localparam muldiv_op_t MD_NONE   = 3'd0;
    localparam muldiv_op_t MD_MUL_LO = 3'd1;
    localparam muldiv_op_t MD_MUL_HI = 3'd2;
    localparam muldiv_op_t MD_DIV    = 3'd3;
    localparam muldiv_op_t MD_MOD    = 3'd4;

    typedef enum logic [1:0] {
        LD_WAIT,
        LD_HELD,
        LD_DROP
    } load_state_t;

endpackage
